// ==== icache.f ====
+incdir+include
logic/icache_pkg.sv
logic/icache_sram.sv
logic/icache_set_state.sv
logic/icache_lookup.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  # cache RTL, package first
  - files:
      - logic/icache_pkg.sv
      - logic/icache_sram.sv
      - logic/icache_set_state.sv
      - logic/icache_lookup.sv
      - logic/icache_ctrl.sv
      - logic/icache_top.sv

  # simulation only
  - target: test
    files:
      - verif/icache_mem_model.sv
      - verif/icache_tb.sv

// ==== verif/icache_tb.sv ====
`include "icache_cfg.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam logic [31:0] WORD_KEY   = 32'h5a5a_c3c3;
    localparam int          RAND_SEED  = 32'h33f1f56f;
    localparam int          NUM_RANDOM = 200;
    localparam int          NUM_REQ    = 40 + NUM_RANDOM;
    // worst miss is about 11 cycles, idle gaps add up to 3 more
    localparam int          MAX_CYCLES = NUM_REQ * 14 + 200;

    logic                      clk;
    logic                      rst;
    logic                      valid;
    icache_index_t             index;
    icache_tag_t               tag;
    icache_offset_t            offset;
    logic                      addr_ok;
    logic                      data_ok;
    icache_word_t              rdata;
    logic                      mem_req_valid;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      mem_req_ready;
    logic                      mem_resp_valid;
    icache_line_t              mem_rdata;

    string  test_name;
    integer seed;
    int     cyc = 0;
    int     err_cnt = 0;

    // accepted requests still waiting for data_ok, oldest first
    logic [31:0] addr_q[$];
    logic        hit_q[$];
    int          acc_q[$];
    int          pending;
    logic [31:0] head_addr;
    logic        head_hit;
    logic        head_miss;
    int          head_acc;
    logic        miss_fetched;
    logic        was_stalled;
    logic [31:0] stalled_addr;

    // seen at the falling edge, applied at the next rising edge
    logic        took_req;
    logic        took_resp;
    logic        took_mem;
    logic        took_stall;
    logic [31:0] took_addr;
    logic [31:0] took_mem_addr;

    // expected contents per set
    icache_tag_t ref_tag [`ICACHE_SETS][2];
    logic [1:0]  ref_valid [`ICACHE_SETS];
    logic        ref_ptr [`ICACHE_SETS];

    icache_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .index          (index),
        .tag            (tag),
        .offset         (offset),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_addr       (mem_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata)
    );

    icache_mem_model #(
        .WORD_KEY (WORD_KEY),
        .SEED     (RAND_SEED)
    ) mem_i (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_addr       (mem_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word stored at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ WORD_KEY;
    endfunction

    function automatic logic [31:0] line_of(input icache_tag_t t, input icache_index_t i);
        return {t, i, 3'b000};
    endfunction

    // hit or miss by the replacement rule, filling the model on a miss
    function automatic logic model_access(input logic [31:0] a);
        icache_index_t i;
        icache_tag_t   t;
        logic          way;
        i = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        t = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        if ((ref_valid[i][0] && ref_tag[i][0] == t) || (ref_valid[i][1] && ref_tag[i][1] == t)) begin
            return 1'b1;
        end
        if (!ref_valid[i][0]) begin
            way = 1'b0;
        end else if (!ref_valid[i][1]) begin
            way = 1'b1;
        end else begin
            way = ref_ptr[i];
        end
        ref_valid[i][way] = 1'b1;
        ref_tag[i][way]   = t;
        ref_ptr[i]        = ~way;
        return 1'b0;
    endfunction

    task automatic stop_on_error();
        err_cnt++;
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string check, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("[ERROR] %s (%s): expected %0h, actual %0h", test_name, check, expected, actual);
        stop_on_error();
    endtask

    // call 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic issue(input logic [31:0] a);
        valid  = 1'b1;
        tag    = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        index  = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        offset = a[`ICACHE_OFFSET_W-1:0];
        do begin
            @(negedge clk);
        end while (!addr_ok);
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
        end while (pending != 0);
        @(posedge clk);
        #2;
    endtask

    task automatic pulse_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    always @(negedge clk) begin
        took_req      <= valid && addr_ok;
        took_addr     <= {tag, index, offset};
        took_resp     <= data_ok;
        took_mem      <= mem_req_valid && mem_req_ready;
        took_stall    <= mem_req_valid && !mem_req_ready;
        took_mem_addr <= mem_addr;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                ref_valid[s] = 2'b00;
                ref_ptr[s]   = 1'b0;
            end
            addr_q.delete();
            hit_q.delete();
            acc_q.delete();
            miss_fetched = 1'b0;
            was_stalled  = 1'b0;
        end else begin
            if (took_resp && addr_q.size() != 0) begin
                addr_q.delete(0);
                hit_q.delete(0);
                acc_q.delete(0);
                miss_fetched = 1'b0;
            end
            if (took_mem) begin
                miss_fetched = 1'b1;
            end
            if (took_req) begin
                addr_q.push_back(took_addr);
                hit_q.push_back(model_access(took_addr));
                acc_q.push_back(cyc);
            end
            was_stalled  = took_stall;
            stalled_addr = took_mem_addr;
        end
        pending   = addr_q.size();
        head_addr = (pending != 0) ? addr_q[0] : '0;
        head_hit  = (pending != 0) ? hit_q[0] : 1'b0;
        head_acc  = (pending != 0) ? acc_q[0] : 0;
        head_miss = (pending != 0) && !head_hit;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d requests outstanding", cyc, pending);
            stop_on_error();
        end
    end

    // all checks sample at the falling edge where every signal is settled
    a_reset_idle: assert property (@(negedge clk)
        rst |-> {addr_ok, data_ok, mem_req_valid} == 3'b100)
        else value_error("idle after reset", 64'(3'b100), 64'({addr_ok, data_ok, mem_req_valid}));

    a_resp_expected: assert property (@(negedge clk) disable iff (rst)
        data_ok |-> pending != 0)
        else begin
            $display("[ERROR] %s: data_ok with no request outstanding", test_name);
            stop_on_error();
        end

    a_rdata: assert property (@(negedge clk) disable iff (rst)
        data_ok |-> rdata == mem_word(head_addr))
        else value_error("rdata", 64'(mem_word(head_addr)), 64'(rdata));

    a_hit_latency: assert property (@(negedge clk) disable iff (rst)
        data_ok && head_hit |-> (cyc - head_acc) == 1)
        else value_error("hit latency", 64'(1), 64'(cyc - head_acc));

    // a hit leaves room for the next request in the same cycle
    a_addr_ok_hit: assert property (@(negedge clk) disable iff (rst)
        data_ok && head_hit |-> addr_ok)
        else value_error("addr_ok on hit", 64'(1), 64'(addr_ok));

    a_hit_or_miss: assert property (@(negedge clk) disable iff (rst)
        data_ok |-> miss_fetched == !head_hit)
        else value_error("memory fetch", 64'(!head_hit), 64'(miss_fetched));

    a_mem_addr: assert property (@(negedge clk) disable iff (rst)
        mem_req_valid |-> mem_addr == {head_addr[31:3], 3'b000})
        else value_error("mem_addr", 64'({head_addr[31:3], 3'b000}), 64'(mem_addr));

    a_mem_hold: assert property (@(negedge clk) disable iff (rst)
        was_stalled |-> mem_req_valid && mem_addr == stalled_addr)
        else value_error("request held", 64'({1'b1, stalled_addr}),
                         64'({mem_req_valid, mem_addr}));

    a_addr_ok_miss: assert property (@(negedge clk) disable iff (rst)
        head_miss |-> !addr_ok)
        else value_error("addr_ok during miss", 64'(0), 64'(addr_ok));

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        seed      = RAND_SEED;
        rst       = 1'b1;
        valid     = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // first word misses, second word of the same line hits
        test_name = "fill";
        for (int i = 0; i < 8; i++) begin
            issue(32'h1000_0000 + i * 8);
            issue(32'h1000_0004 + i * 8);
        end
        drain();

        // back-to-back hits
        test_name = "hit stream";
        for (int i = 0; i < 16; i++) begin
            issue(32'h1000_0000 + i * 4);
        end
        drain();

        // three tags in one set
        test_name = "replacement";
        issue(line_of(23'h01111, 6'h2a));
        issue(line_of(23'h02222, 6'h2a));
        issue(line_of(23'h03333, 6'h2a));
        issue(line_of(23'h02222, 6'h2a) + 4);
        issue(line_of(23'h01111, 6'h2a));
        issue(line_of(23'h02222, 6'h2a));
        drain();

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            a = {21'h0001c0, r[1:0], 4'h0, r[3:2], r[4], 2'b00};
            issue(a);
            if (r[6:5] != 2'b00) begin
                drain();
                repeat (int'(r[6:5])) @(posedge clk);
                #2;
            end
        end
        drain();

        // a line cached before the reset must miss again
        test_name = "mid-run reset";
        pulse_reset();
        issue(line_of(23'h02222, 6'h2a));
        issue(line_of(23'h02222, 6'h2a) + 4);
        drain();

        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verif/icache_mem_model.sv ====
`include "icache_cfg.svh"

module icache_mem_model #(
    parameter logic [31:0] WORD_KEY = 32'h0,
    parameter int          SEED     = 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_req_valid,
    input  logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      mem_req_ready,
    output logic                      mem_resp_valid,
    output icache_pkg::icache_line_t  mem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        ph_idle,
        ph_offer,
        ph_busy
    } phase_t;

    phase_t                    phase;
    integer                    seed;
    int                        stall_left;
    int                        delay_left;
    logic [`ICACHE_ADDR_W-1:0] line_addr;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ WORD_KEY;
    endfunction

    // outputs change 2 ns after the rising edge, like the stimulus
    initial begin
        seed           = SEED;
        phase          = ph_idle;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_rdata      = '0;
        line_addr      = '0;
        delay_left     = 0;
        stall_left     = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge clk);
            #2;
            mem_resp_valid = 1'b0;
            if (rst) begin
                mem_req_ready = 1'b0;
                phase         = ph_idle;
            end else if (phase == ph_idle) begin
                if (mem_req_valid) begin
                    if (stall_left == 0) begin
                        mem_req_ready = 1'b1;
                        line_addr     = mem_addr;
                        phase         = ph_offer;
                    end else begin
                        stall_left--;
                    end
                end
            end else begin
                if (phase == ph_offer) begin
                    // request went across on this edge
                    mem_req_ready = 1'b0;
                    delay_left    = $unsigned($random(seed)) % 4;
                    phase         = ph_busy;
                end
                if (delay_left == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_rdata      = {word_at(line_addr + 4), word_at(line_addr)};
                    stall_left     = $unsigned($random(seed)) % 4;
                    phase          = ph_idle;
                end else begin
                    delay_left--;
                end
            end
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`include "icache_cfg.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid,
    input  icache_pkg::icache_index_t  index,
    input  icache_pkg::icache_tag_t    tag,
    input  icache_pkg::icache_offset_t offset,
    output logic                       addr_ok,
    output logic                       data_ok,
    output icache_pkg::icache_word_t   rdata,
    output logic                       mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  mem_addr,
    input  logic                       mem_req_ready,
    input  logic                       mem_resp_valid,
    input  icache_pkg::icache_line_t   mem_rdata
);

    import icache_pkg::*;

    logic                 hit;
    icache_way_t          hit_way;
    icache_word_t         hit_word;
    icache_way_t          victim;
    logic [1:0]           valid_bits;
    logic                 sram_en;
    icache_index_t        sram_addr;
    logic [1:0]           tag_we;
    logic [1:0]           data_we;
    icache_tag_t          tag_wdata;
    icache_line_t         line_wdata;
    icache_tag_t          req_tag;
    icache_offset_t       req_offset;
    logic                 fill;
    icache_index_t        fill_index;
    icache_way_t          fill_way;
    icache_tag_t [1:0]    way_tags;
    icache_line_t [1:0]   way_lines;

    icache_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .index          (index),
        .tag            (tag),
        .offset         (offset),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .hit            (hit),
        .hit_way        (hit_way),
        .hit_word       (hit_word),
        .victim         (victim),
        .mem_req_valid  (mem_req_valid),
        .mem_addr       (mem_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata),
        .sram_en        (sram_en),
        .sram_addr      (sram_addr),
        .tag_we         (tag_we),
        .data_we        (data_we),
        .tag_wdata      (tag_wdata),
        .line_wdata     (line_wdata),
        .req_tag        (req_tag),
        .req_offset     (req_offset),
        .fill           (fill),
        .fill_index     (fill_index),
        .fill_way       (fill_way)
    );

    // lookup and victim both work on the buffered set
    icache_set_state set_state_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (fill_index),
        .fill         (fill),
        .fill_index   (fill_index),
        .fill_way     (fill_way),
        .valid_bits   (valid_bits),
        .victim       (victim)
    );

    icache_lookup lookup_i (
        .way_tags   (way_tags),
        .way_lines  (way_lines),
        .valid_bits (valid_bits),
        .req_tag    (req_tag),
        .req_offset (req_offset),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_word   (hit_word)
    );

    // one tag array and one data array per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_sram #(
            .entry_t (icache_tag_t),
            .DEPTH   (`ICACHE_SETS)
        ) tag_sram_i (
            .clk   (clk),
            .en    (sram_en),
            .we    (tag_we[w]),
            .addr  (sram_addr),
            .wdata (tag_wdata),
            .rdata (way_tags[w])
        );

        icache_sram #(
            .entry_t (icache_line_t),
            .DEPTH   (`ICACHE_SETS)
        ) data_sram_i (
            .clk   (clk),
            .en    (sram_en),
            .we    (data_we[w]),
            .addr  (sram_addr),
            .wdata (line_wdata),
            .rdata (way_lines[w])
        );
    end

endmodule

// ==== logic/icache_ctrl.sv ====
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // fetch side
    input  logic                       valid,
    input  icache_pkg::icache_index_t  index,
    input  icache_pkg::icache_tag_t    tag,
    input  icache_pkg::icache_offset_t offset,
    output logic                       addr_ok,
    output logic                       data_ok,
    output icache_pkg::icache_word_t   rdata,
    // from lookup and set state
    input  logic                       hit,
    input  icache_pkg::icache_way_t    hit_way,
    input  icache_pkg::icache_word_t   hit_word,
    input  icache_pkg::icache_way_t    victim,
    // memory side
    output logic                       mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  mem_addr,
    input  logic                       mem_req_ready,
    input  logic                       mem_resp_valid,
    input  icache_pkg::icache_line_t   mem_rdata,
    // array control
    output logic                       sram_en,
    output icache_pkg::icache_index_t  sram_addr,
    output logic [1:0]                 tag_we,
    output logic [1:0]                 data_we,
    output icache_pkg::icache_tag_t    tag_wdata,
    output icache_pkg::icache_line_t   line_wdata,
    // buffered request for lookup
    output icache_pkg::icache_tag_t    req_tag,
    output icache_pkg::icache_offset_t req_offset,
    // set state update
    output logic                       fill,
    output icache_pkg::icache_index_t  fill_index,
    output icache_pkg::icache_way_t    fill_way
);

    import icache_pkg::*;

    icache_state_t state;
    icache_state_t next_state;

    icache_index_t req_index;
    icache_line_t  miss_line;
    icache_word_t  miss_word;
    logic          accept;
    logic          lookup_hit;
    logic [1:0]    fill_mask;

    assign lookup_hit = (state == lookup) && hit;

    // new request can enter while idle or behind a hit
    assign addr_ok = (state == idle) || lookup_hit;
    assign accept  = valid && addr_ok;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (valid) begin
                    next_state = lookup;
                end
            end
            lookup: begin
                if (!hit) begin
                    next_state = miss_req;
                end else if (valid) begin
                    next_state = lookup;
                end else begin
                    next_state = idle;
                end
            end
            miss_req: begin
                if (mem_req_ready) begin
                    next_state = miss_wait;
                end
            end
            miss_wait: begin
                if (mem_resp_valid) begin
                    next_state = refill;
                end
            end
            refill: begin
                next_state = respond;
            end
            respond: begin
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
        end
    end

    // miss buffer holds the returned line until refill and respond
    always_ff @(posedge clk) begin
        if ((state == miss_wait) && mem_resp_valid) begin
            miss_line <= mem_rdata;
        end
    end

    // line address toward memory
    assign mem_req_valid = (state == miss_req);
    assign mem_addr      = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};

    // read on accept, write the victim way on refill
    assign sram_en   = accept || (state == refill);
    assign sram_addr = accept ? index : req_index;

    assign fill       = (state == refill);
    assign fill_index = req_index;
    assign fill_way   = victim;
    assign fill_mask  = fill ? (2'b01 << fill_way) : 2'b00;

    assign tag_we     = fill_mask;
    assign data_we    = fill_mask;
    assign tag_wdata  = req_tag;
    assign line_wdata = miss_line;

    always_comb begin
        if (req_offset[`ICACHE_OFFSET_W-1]) begin
            miss_word = miss_line[`ICACHE_LINE_W-1 -: `ICACHE_WORD_W];
        end else begin
            miss_word = miss_line[`ICACHE_WORD_W-1:0];
        end
    end

    // hit answers from lookup, a miss answers one cycle after refill
    assign data_ok = lookup_hit || (state == respond);

    always_comb begin
        if (state == respond) begin
            rdata = miss_word;
        end else begin
            rdata = hit_word;
        end
    end

endmodule

// ==== logic/icache_lookup.sv ====
`include "icache_cfg.svh"

module icache_lookup (
    input  icache_pkg::icache_tag_t [1:0]  way_tags,
    input  icache_pkg::icache_line_t [1:0] way_lines,
    input  logic [1:0]                     valid_bits,
    input  icache_pkg::icache_tag_t        req_tag,
    input  icache_pkg::icache_offset_t     req_offset,
    output logic                           hit,
    output icache_pkg::icache_way_t        hit_way,
    output icache_pkg::icache_word_t       hit_word
);

    import icache_pkg::*;

    logic [1:0]   way_hit;
    icache_line_t hit_line;

    // a way only counts when its valid bit is set
    assign way_hit[0] = valid_bits[0] && (way_tags[0] == req_tag);
    assign way_hit[1] = valid_bits[1] && (way_tags[1] == req_tag);

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign hit_line = way_lines[hit_way];

    // upper offset bit picks the word
    always_comb begin
        if (req_offset[`ICACHE_OFFSET_W-1]) begin
            hit_word = hit_line[`ICACHE_LINE_W-1 -: `ICACHE_WORD_W];
        end else begin
            hit_word = hit_line[`ICACHE_WORD_W-1:0];
        end
    end

endmodule

// ==== logic/icache_set_state.sv ====
`include "icache_cfg.svh"

module icache_set_state (
    input  logic                      clk,
    input  logic                      rst,
    input  icache_pkg::icache_index_t lookup_index,
    input  logic                      fill,
    input  icache_pkg::icache_index_t fill_index,
    input  icache_pkg::icache_way_t   fill_way,
    output logic [1:0]                valid_bits,
    output icache_pkg::icache_way_t   victim
);

    import icache_pkg::*;

    // one valid bit per way, one round-robin pointer per set
    logic [`ICACHE_SETS-1:0][1:0] valid_q;
    logic [`ICACHE_SETS-1:0]      rr_q;

    assign valid_bits = valid_q[lookup_index];

    // fill an empty way before evicting anything
    always_comb begin
        if (!valid_bits[0]) begin
            victim = 1'b0;
        end else if (!valid_bits[1]) begin
            victim = 1'b1;
        end else begin
            victim = icache_way_t'(rr_q[lookup_index]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (fill) begin
            valid_q[fill_index][fill_way] <= 1'b1;
            // next eviction goes to the other way
            rr_q[fill_index] <= ~fill_way;
        end
    end

endmodule

// ==== logic/icache_sram.sv ====
module icache_sram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // one port: either a write or a registered read per enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== logic/icache_pkg.sv ====
`include "icache_cfg.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]    icache_tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  icache_index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] icache_offset_t;

    // lower word sits at offset 0
    typedef logic [`ICACHE_LINE_W-1:0]   icache_line_t;
    typedef logic [`ICACHE_WORD_W-1:0]   icache_word_t;

    typedef logic                        icache_way_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_wait,
        refill,
        respond
    } icache_state_t;

endpackage

// ==== include/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// address split: tag | index | offset
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

// 64 sets of two ways each
`define ICACHE_SETS     64

// one line holds two instruction words
`define ICACHE_LINE_W   64
`define ICACHE_WORD_W   32

// byte address toward memory
`define ICACHE_ADDR_W   32

`endif
